/* design/rv_pkg.sv */
/* shared widths, opcodes, state codes and the i/o map of the rv32i subset core
   only address bits 17:16 select i/o space, the rest of the map is 128 KB of ram */
package rv_pkg;

  localparam int XLEN   = 32;  // data and address width
  localparam int REG_AW = 5;   // register index width

  // 7-bit major opcodes of the supported instructions
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;  // addi
  localparam logic [6:0] OP_REG    = 7'b0110011;  // add, sub
  localparam logic [6:0] OP_LOAD   = 7'b0000011;  // lw, lbu
  localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw, sb
  localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq, bne
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  // decoded operation class
  typedef enum logic [2:0] {
    CLS_ALU_IMM,
    CLS_ALU_REG,
    CLS_LUI,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL
  } op_class_e;

  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_EQ,   // branch if equal
    ALU_NE    // branch if not equal
  } alu_op_e;

  // controller states
  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXEC,
    MEM,
    WB,
    HALT
  } ctrl_state_e;

  localparam logic [XLEN-1:0] IO_OUT_ADDR  = 32'h0003_0000;  // byte write prints a char
  localparam logic [XLEN-1:0] IO_HALT_ADDR = 32'h0003_0004;  // any write stops the core
  localparam logic [1:0]      IO_SEL       = 2'b11;          // addr[17:16] in i/o space
  localparam logic [XLEN-1:0] RESET_PC     = 32'h0000_0000;

endpackage

/* design/byte_counter.sv */
/* counts the byte beats of one bus transfer, the start cycle is beat 0
   lengths of 1 or 4 only, a start is ignored while a run is busy */
module byte_counter (
  input  logic       clk_in,
  input  logic       i_arst_n,
  input  logic       i_en,
  input  logic       i_start,      // first beat of a new transfer
  input  logic [2:0] i_len,        // number of beats
  output logic [1:0] o_beat_idx,
  output logic       o_last_beat,
  output logic       o_busy
);

  logic [1:0] idx_q;
  logic [1:0] last_q;  // index of the final beat
  logic       busy_q;

  assign o_beat_idx  = busy_q ? idx_q : 2'd0;
  assign o_last_beat = busy_q ? (idx_q == last_q) : (i_start && (i_len == 3'd1));
  assign o_busy      = busy_q;

  always_ff @(posedge clk_in or negedge i_arst_n) begin
    if (!i_arst_n) begin
      idx_q  <= 2'd0;
      last_q <= 2'd0;
      busy_q <= 1'b0;
    end else if (i_en) begin
      if (i_start && !busy_q) begin
        busy_q <= (i_len != 3'd1);       // one-beat transfer is done already
        idx_q  <= 2'd1;
        last_q <= 2'(i_len - 3'd1);
      end else if (busy_q) begin
        if (idx_q == last_q)
          busy_q <= 1'b0;
        else
          idx_q <= idx_q + 2'd1;
      end
    end
  end

endmodule

/* design/decoder.sv */
/* combinational decode of the supported rv32i subset
   unsupported opcodes fall back to the addi class */
module decoder import rv_pkg::*; (
  input  logic [XLEN-1:0]   i_instr,
  output logic [REG_AW-1:0] o_rs1,
  output logic [REG_AW-1:0] o_rs2,
  output logic [REG_AW-1:0] o_rd,
  output logic [XLEN-1:0]   o_imm,
  output op_class_e         o_op_class,
  output alu_op_e           o_alu_op
);

  logic [6:0]      opcode;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = i_instr[6:0];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign o_rd   = i_instr[11:7];

  // sign-extended immediates of each format
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'd0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  always_comb begin
    o_op_class = CLS_ALU_IMM;
    o_alu_op   = ALU_ADD;
    o_imm      = imm_i;
    case (opcode)
      OP_LUI: begin
        o_op_class = CLS_LUI;
        o_imm      = imm_u;
      end
      OP_REG: begin
        o_op_class = CLS_ALU_REG;
        o_alu_op   = i_instr[30] ? ALU_SUB : ALU_ADD;  // funct7 bit 5
      end
      OP_LOAD:  o_op_class = CLS_LOAD;
      OP_STORE: begin
        o_op_class = CLS_STORE;
        o_imm      = imm_s;
      end
      OP_BRANCH: begin
        o_op_class = CLS_BRANCH;
        o_alu_op   = i_instr[12] ? ALU_NE : ALU_EQ;   // funct3 bit 0
        o_imm      = imm_b;
      end
      OP_JAL: begin
        o_op_class = CLS_JAL;
        o_imm      = imm_j;
      end
      default: ;  // OP_IMM and unknowns decode as addi
    endcase
  end

endmodule

/* design/reg_file.sv */
/* 32 x 32-bit register file, two async reads and one write
   x0 reads as zero, x10 is exported for debug */
module reg_file import rv_pkg::*; (
  input  logic              clk_in,
  input  logic              i_arst_n,
  input  logic              i_en,
  input  logic              i_we,
  input  logic [REG_AW-1:0] i_rs1,
  input  logic [REG_AW-1:0] i_rs2,
  input  logic [REG_AW-1:0] i_rd,
  input  logic [XLEN-1:0]   i_wdata,
  output logic [XLEN-1:0]   o_rs1_val,
  output logic [XLEN-1:0]   o_rs2_val,
  output logic [XLEN-1:0]   o_dbg_x10
);

  logic [XLEN-1:0] regs [2**REG_AW];

  always_ff @(posedge clk_in or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 2**REG_AW; i++)
        regs[i] <= '0;
    end else if (i_en && i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;  // x0 stays zero
    end
  end

  assign o_rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];
  assign o_dbg_x10 = regs[10];  // a0

endmodule

/* design/alu.sv */
/* adder/subtractor and branch compare for the rv32i subset
   result is the effective address for loads and stores */
module alu import rv_pkg::*; (
  input  logic [XLEN-1:0] i_a,         // rs1
  input  logic [XLEN-1:0] i_b,         // rs2
  input  logic [XLEN-1:0] i_imm,
  input  op_class_e       i_op_class,
  input  alu_op_e         i_alu_op,
  output logic [XLEN-1:0] o_result,
  output logic            o_br_taken
);

  logic [XLEN-1:0] opnd_b;
  logic            equal;

  // register operand for add/sub and compares, immediate otherwise
  assign opnd_b = ((i_op_class == CLS_ALU_REG) || (i_op_class == CLS_BRANCH)) ? i_b : i_imm;

  assign equal = (i_a == opnd_b);

  always_comb begin
    case (i_alu_op)
      ALU_SUB: o_result = i_a - opnd_b;
      default: o_result = i_a + opnd_b;  // add, address calc
    endcase
  end

  always_comb begin
    o_br_taken = 1'b0;
    if (i_op_class == CLS_BRANCH) begin
      case (i_alu_op)
        ALU_EQ:  o_br_taken = equal;
        ALU_NE:  o_br_taken = !equal;
        default: o_br_taken = 1'b0;
      endcase
    end
  end

endmodule

/* design/mem_port.sv */
/* byte bus driver, read data returns one cycle after its address
   words are little endian and assembled from the registered beat index */
module mem_port import rv_pkg::*; (
  input  logic            clk_in,
  input  logic            i_arst_n,
  input  logic            i_en,
  input  logic            i_active,      // beat on the bus this cycle
  input  logic            i_write,
  input  logic [XLEN-1:0] i_addr,        // base address of the transfer
  input  logic [XLEN-1:0] i_wdata,
  input  logic [1:0]      i_beat_idx,
  input  logic [7:0]      i_mem_din,
  output logic [XLEN-1:0] o_mem_a,
  output logic [7:0]      o_mem_dout,
  output logic            o_mem_wr,
  output logic [XLEN-1:0] o_rdata_word
);

  logic            rd_pend_q;  // read beat issued last cycle
  logic [1:0]      rd_idx_q;   // its byte lane
  logic [XLEN-1:0] word_q;

  assign o_mem_a    = i_active ? (i_addr + XLEN'(i_beat_idx)) : '0;
  assign o_mem_dout = i_wdata[{i_beat_idx, 3'b000} +: 8];  // lane of this beat
  assign o_mem_wr   = i_active && i_write;

  always_ff @(posedge clk_in or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_pend_q <= 1'b0;
      rd_idx_q  <= 2'd0;
    end else if (i_en) begin
      rd_pend_q <= i_active && !i_write;
      rd_idx_q  <= i_beat_idx;
    end
  end

  // returning byte lands in the lane of the address it answers
  always_ff @(posedge clk_in) begin
    if (i_en && rd_pend_q)
      word_q[{rd_idx_q, 3'b000} +: 8] <= i_mem_din;
  end

  // merge the byte still on the bus so the word is ready right after the last beat
  always_comb begin
    o_rdata_word = word_q;
    if (rd_pend_q)
      o_rdata_word[{rd_idx_q, 3'b000} +: 8] = i_mem_din;
  end

endmodule

/* design/cpu_ctrl.sv */
/* sequences fetch, decode, exec, mem and wb for one instruction at a time
   char stores to 0x30000 wait while the output buffer is full, a store to 0x30004 halts */
module cpu_ctrl import rv_pkg::*; (
  input  logic            clk_in,
  input  logic            i_arst_n,
  input  logic            i_en,              // core enable, freeze when low
  input  logic            i_io_buffer_full,
  input  logic            i_last_beat,       // final byte beat of this transfer
  input  op_class_e       i_op_class,
  input  logic [XLEN-1:0] i_alu_result,      // sum or load/store address
  input  logic            i_br_taken,
  input  logic [XLEN-1:0] i_imm,
  input  logic [XLEN-1:0] i_rs2_val,         // store data
  input  logic [XLEN-1:0] i_rdata_word,
  output logic            o_cnt_start,
  output logic [2:0]      o_cnt_len,         // beats, 1 or 4
  output logic            o_bus_active,
  output logic            o_bus_write,
  output logic [XLEN-1:0] o_bus_addr,
  output logic [XLEN-1:0] o_bus_wdata,
  output logic [XLEN-1:0] o_instr,
  output logic [XLEN-1:0] o_pc,
  output logic            o_rf_we,
  output logic [XLEN-1:0] o_rf_wdata,
  output logic            o_halted
);

  ctrl_state_e     state_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] ir_q;
  logic [XLEN-1:0] npc_q;      // next pc, settled in exec
  logic [XLEN-1:0] res_q;      // write-back value for non-loads
  logic            started_q;  // beats of a multi-beat transfer under way
  logic            tail_q;     // waiting one cycle for the last read byte
  logic            is_store;
  logic            is_mem_op;
  logic            byte_acc;
  logic            io_space;
  logic            out_hit;
  logic            halt_hit;
  logic            out_stall;
  logic            beat_phase;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] exec_val;

  assign is_store  = (i_op_class == CLS_STORE);
  assign is_mem_op = is_store || (i_op_class == CLS_LOAD);
  assign byte_acc  = ~ir_q[13];  // funct3 of lbu/sb has bit 1 clear

  // i/o decode on the effective address
  assign io_space  = (i_alu_result[17:16] == IO_SEL);
  assign out_hit   = io_space && (i_alu_result[15:0] == IO_OUT_ADDR[15:0]);
  assign halt_hit  = io_space && (i_alu_result[15:0] == IO_HALT_ADDR[15:0]);
  assign out_stall = (state_q == MEM) && is_store && out_hit && !started_q && i_io_buffer_full;

  // a beat goes out every fetch/mem cycle except the read tail and a held char store
  assign beat_phase   = ((state_q == FETCH) || ((state_q == MEM) && !out_stall)) && !tail_q;
  assign o_bus_active = beat_phase;
  assign o_bus_write  = (state_q == MEM) && is_store;
  assign o_bus_addr   = (state_q == FETCH) ? pc_q : i_alu_result;
  assign o_bus_wdata  = i_rs2_val;
  assign o_cnt_start  = beat_phase && !started_q;  // first beat of a transfer
  assign o_cnt_len    = ((state_q == MEM) && byte_acc) ? 3'd1 : 3'd4;

  assign pc_plus4 = pc_q + 32'd4;

  always_comb begin
    next_pc  = pc_plus4;
    exec_val = i_alu_result;
    case (i_op_class)
      CLS_LUI:    exec_val = i_imm;  // u-imm already shifted
      CLS_JAL: begin
        next_pc  = pc_q + i_imm;
        exec_val = pc_plus4;        // link value
      end
      CLS_BRANCH: if (i_br_taken) next_pc = pc_q + i_imm;
      default:    ;
    endcase
  end

  // x0 writes are dropped in the register file
  assign o_rf_we = (state_q == WB) && !is_store && (i_op_class != CLS_BRANCH);

  always_comb begin
    if (i_op_class == CLS_LOAD)
      o_rf_wdata = byte_acc ? {24'd0, i_rdata_word[7:0]} : i_rdata_word;  // lbu zero-ext
    else
      o_rf_wdata = res_q;
  end

  always_ff @(posedge clk_in or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= FETCH;
      pc_q      <= RESET_PC;
      started_q <= 1'b0;
      tail_q    <= 1'b0;
    end else if (i_en) begin
      if (o_cnt_start)
        started_q <= ~i_last_beat;  // single-beat transfers never start a run
      else if (i_last_beat)
        started_q <= 1'b0;

      case (state_q)
        FETCH: begin
          if (tail_q) begin
            tail_q  <= 1'b0;
            state_q <= DECODE;
          end else if (i_last_beat) begin
            tail_q <= 1'b1;
          end
        end
        DECODE: state_q <= EXEC;  // operands read from rf this cycle
        EXEC:   state_q <= is_mem_op ? MEM : WB;
        MEM: begin
          if (tail_q) begin
            tail_q  <= 1'b0;
            state_q <= WB;
          end else if (i_last_beat) begin
            if (is_store)
              state_q <= halt_hit ? HALT : WB;
            else
              tail_q <= 1'b1;    // load byte still to come
          end
        end
        WB: begin
          pc_q    <= npc_q;
          state_q <= FETCH;
        end
        default: state_q <= HALT;  // halt is sticky
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (i_en) begin
      if ((state_q == FETCH) && tail_q)
        ir_q <= i_rdata_word;
      if (state_q == EXEC) begin
        npc_q <= next_pc;
        res_q <= exec_val;
      end
    end
  end

  assign o_instr  = ir_q;
  assign o_pc     = pc_q;
  assign o_halted = (state_q == HALT);

endmodule

/* design/cpu.sv */
/* multicycle rv32i subset core on a byte bus, one instruction in flight at a time
   the whole core freezes while i_rdy is low and bus outputs hold their values */
module cpu import rv_pkg::*; (
  input  logic            clk_in,            // system clock
  input  logic            i_arst_n,          // async reset, active low
  input  logic            i_rdy,             // core enable, pause when low
  input  logic [7:0]      i_mem_din,         // read byte, one cycle after address
  output logic [7:0]      o_mem_dout,        // write byte
  output logic [XLEN-1:0] o_mem_a,           // byte address, bits 17:0 decoded
  output logic            o_mem_wr,          // 1 for write
  input  logic            i_io_buffer_full,  // output fifo full, hold char writes
  output logic [XLEN-1:0] o_dbgreg_dout,     // x10
  output logic            o_halted
);

  logic                   cnt_start;
  logic [2:0]             cnt_len;
  logic [1:0]             beat_idx;
  logic                   last_beat;
  logic                   bus_active;
  logic                   bus_write;
  logic [XLEN-1:0]        bus_addr;
  logic [XLEN-1:0]        bus_wdata;
  logic [XLEN-1:0]        rdata_word;    // assembled read word
  logic [XLEN-1:0]        instr;
  logic [REG_AW-1:0]      rs1;
  logic [REG_AW-1:0]      rs2;
  logic [REG_AW-1:0]      rd;
  logic [XLEN-1:0]        imm;
  op_class_e              op_class;
  alu_op_e                alu_op;
  logic [XLEN-1:0]        rs1_val;
  logic [XLEN-1:0]        rs2_val;
  logic [XLEN-1:0]        alu_result;
  logic                   br_taken;
  logic                   rf_we;
  logic [XLEN-1:0]        rf_wdata;

  cpu_ctrl u_ctrl (
    .clk_in           (clk_in),
    .i_arst_n         (i_arst_n),
    .i_en             (i_rdy),
    .i_io_buffer_full (i_io_buffer_full),
    .i_last_beat      (last_beat),
    .i_op_class       (op_class),
    .i_alu_result     (alu_result),
    .i_br_taken       (br_taken),
    .i_imm            (imm),
    .i_rs2_val        (rs2_val),
    .i_rdata_word     (rdata_word),
    .o_cnt_start      (cnt_start),
    .o_cnt_len        (cnt_len),
    .o_bus_active     (bus_active),
    .o_bus_write      (bus_write),
    .o_bus_addr       (bus_addr),
    .o_bus_wdata      (bus_wdata),
    .o_instr          (instr),
    .o_pc             (),              // pc only needed inside the controller
    .o_rf_we          (rf_we),
    .o_rf_wdata       (rf_wdata),
    .o_halted         (o_halted)
  );

  byte_counter u_cnt (
    .clk_in      (clk_in),
    .i_arst_n    (i_arst_n),
    .i_en        (i_rdy),
    .i_start     (cnt_start),
    .i_len       (cnt_len),
    .o_beat_idx  (beat_idx),
    .o_last_beat (last_beat),
    .o_busy      ()
  );

  decoder u_dec (
    .i_instr    (instr),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_op_class (op_class),
    .o_alu_op   (alu_op)
  );

  reg_file u_rf (
    .clk_in    (clk_in),
    .i_arst_n  (i_arst_n),
    .i_en      (i_rdy),
    .i_we      (rf_we),
    .i_rs1     (rs1),
    .i_rs2     (rs2),
    .i_rd      (rd),
    .i_wdata   (rf_wdata),
    .o_rs1_val (rs1_val),
    .o_rs2_val (rs2_val),
    .o_dbg_x10 (o_dbgreg_dout)
  );

  alu u_alu (
    .i_a        (rs1_val),
    .i_b        (rs2_val),
    .i_imm      (imm),
    .i_op_class (op_class),
    .i_alu_op   (alu_op),
    .o_result   (alu_result),
    .o_br_taken (br_taken)
  );

  mem_port u_mem (
    .clk_in       (clk_in),
    .i_arst_n     (i_arst_n),
    .i_en         (i_rdy),
    .i_active     (bus_active),
    .i_write      (bus_write),
    .i_addr       (bus_addr),
    .i_wdata      (bus_wdata),
    .i_beat_idx   (beat_idx),
    .i_mem_din    (i_mem_din),
    .o_mem_a      (o_mem_a),
    .o_mem_dout   (o_mem_dout),
    .o_mem_wr     (o_mem_wr),
    .o_rdata_word (rdata_word)
  );

endmodule

/* verification/tb_clock.sv */
/* 20 unit clock, reset low for the first 5 cycles
   i_rst_req pulls reset low again between programs */
module tb_clock (
  input  logic i_rst_req,  // extra reset from the testbench
  output logic o_clk,
  output logic o_arst_n
);

  logic por_n;  // power-on reset released

  initial begin
    o_clk = 1'b0;
    por_n = 1'b0;
    repeat (5) @(posedge o_clk);
    por_n = 1'b1;
  end

  always #10 o_clk = ~o_clk;

  assign o_arst_n = por_n && !i_rst_req;

endmodule

/* verification/tb_cpu.sv */
/* runs hand-assembled programs on the core with a 128 KB byte memory and i/o model
   programs 3 and 4 repeat the loop with random i_rdy pauses and output-buffer stalls */
module tb_cpu import rv_pkg::*; ();

  localparam int LOOP_N    = 10;
  localparam int MAX_INSTR = 7 + 3 * LOOP_N;    // instruction count of the loop program
  localparam int LIMIT     = MAX_INSTR * 40 * 4;

  logic        clk_in;
  logic        i_arst_n;
  logic        rst_req;
  logic        i_rdy;
  logic [7:0]  i_mem_din;
  logic [7:0]  o_mem_dout;
  logic [31:0] o_mem_a;
  logic        o_mem_wr;
  logic        i_io_buffer_full;
  logic [31:0] o_dbgreg_dout;
  logic        o_halted;

  logic [7:0]  mem [0:131071];
  logic [7:0]  rd_q;         // byte answered in the next cycle
  logic [7:0]  out_q [$];    // chars written to 0x30000
  integer      seed;
  int          wp;           // program load pointer
  int          cur_prog;
  int          n_seen;
  int          n_out;
  int          cycles;
  bit          running;
  bit          rdy_rand;
  bit          full_rand;

  tb_clock u_clk (.i_rst_req(rst_req), .o_clk(clk_in), .o_arst_n(i_arst_n));

  cpu u_dut (
    .clk_in           (clk_in),
    .i_arst_n         (i_arst_n),
    .i_rdy            (i_rdy),
    .i_mem_din        (i_mem_din),
    .o_mem_dout       (o_mem_dout),
    .o_mem_a          (o_mem_a),
    .o_mem_wr         (o_mem_wr),
    .i_io_buffer_full (i_io_buffer_full),
    .o_dbgreg_dout    (o_dbgreg_dout),
    .o_halted         (o_halted)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_run("value mismatch");
    end
  endtask

  // instruction encoders taking immediates as plain integers
  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [31:0] rs1,
                                        input logic [31:0] f3, input logic [31:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [31:0] rs2,
                                        input logic [31:0] rs1, input logic [31:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_r(input logic [31:0] f7, input logic [31:0] rs2,
                                        input logic [31:0] rs1, input logic [31:0] rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [31:0] rs2,
                                        input logic [31:0] rs1, input logic [31:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [31:0] imm20, input logic [31:0] rd);
    return {imm20[19:0], rd[4:0], OP_LUI};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [31:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  // expected char stream, count and final x10 of each program
  function automatic logic [7:0] expected_output(input int p, input int idx,
                                                 output int len, output logic [31:0] x10);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    logic [7:0]  s [4];
    a = 32'd100;
    b = -32'sd3;
    w = 32'hA1B2_C3D4;
    if (p == 0) begin
      s   = '{8'((a + b) & 32'hff), 8'((a - b) & 32'hff),
              8'(((32'h12345 << 12) + a - b) & 32'hff), 8'h0};
      len = 3;
      x10 = (32'h12345 << 12) + (a - b);
    end else if (p == 1) begin
      s   = '{w[7:0], w[23:16], w[31:24], 8'hff};  // lbu keeps 0xff
      len = 4;
      x10 = 32'h0000_00ff;
    end else begin
      s   = '{8'((LOOP_N * (LOOP_N + 1) / 2) % 256), 8'h0, 8'h0, 8'h0};
      len = 1;
      x10 = 32'(LOOP_N * (LOOP_N + 1) / 2);
    end
    return s[idx & 3];
  endfunction

  task automatic emit(input logic [31:0] w);
    mem[wp]     = w[7:0];
    mem[wp + 1] = w[15:8];
    mem[wp + 2] = w[23:16];
    mem[wp + 3] = w[31:24];
    wp += 4;
  endtask

  task automatic load_prog(input int p);
    logic [31:0] a;
    for (int i = 0; i < 131072; i++) begin
      a      = 32'(i);
      mem[i] = a[7:0] ^ a[15:8] ^ {7'd0, a[16]};  // background pattern
    end
    wp = 0;
    emit(enc_u(32'h30, 5));                        // x5 = i/o base
    if (p == 0) begin
      emit(enc_i(100, 0, 0, 10, OP_IMM));
      emit(enc_i(-3, 0, 0, 11, OP_IMM));
      emit(enc_r(0, 11, 10, 12));                  // add
      emit(enc_r(32'h20, 11, 10, 13));             // sub
      emit(enc_u(32'h12345, 14));
      emit(enc_r(0, 13, 14, 10));
      emit(enc_s(0, 12, 5, 0));
      emit(enc_s(0, 13, 5, 0));
      emit(enc_s(0, 10, 5, 0));
    end else if (p == 1) begin
      emit(enc_i(32'h400, 0, 0, 6, OP_IMM));       // data base
      emit(enc_u(32'hA1B2C, 7));
      emit(enc_i(32'h3D4, 7, 0, 7, OP_IMM));
      emit(enc_s(0, 7, 6, 2));                     // sw
      emit(enc_i(0, 6, 2, 8, OP_LOAD));            // lw
      emit(enc_s(0, 8, 5, 0));
      emit(enc_i(2, 6, 4, 9, OP_LOAD));            // lbu
      emit(enc_s(0, 9, 5, 0));
      emit(enc_i(3, 6, 4, 9, OP_LOAD));
      emit(enc_s(0, 9, 5, 0));
      emit(enc_i(-1, 0, 0, 11, OP_IMM));
      emit(enc_s(16, 11, 6, 0));                   // sb
      emit(enc_i(16, 6, 4, 12, OP_LOAD));
      emit(enc_r(32'h20, 7, 8, 17));
      emit(enc_b(8, 0, 17, 0));                    // beq skips the error char
      emit(enc_s(0, 11, 5, 0));
      emit(enc_s(0, 12, 5, 0));
      emit(enc_i(0, 12, 0, 10, OP_IMM));
    end else begin
      emit(enc_i(0, 0, 0, 10, OP_IMM));
      emit(enc_i(LOOP_N, 0, 0, 11, OP_IMM));
      emit(enc_r(0, 11, 10, 10));                  // loop body
      emit(enc_i(-1, 11, 0, 11, OP_IMM));
      emit(enc_b(-8, 0, 11, 1));                   // bne back
      emit(enc_j(8, 1));
      emit(enc_s(0, 11, 5, 0));                    // jumped over
      emit(enc_s(0, 10, 5, 0));
    end
    emit(enc_s(4, 0, 5, 2));                       // halt store
  endtask

  // memory and i/o model that acts only on enabled edges
  always @(posedge clk_in) begin
    if (i_rdy && i_arst_n) begin
      rd_q = mem[o_mem_a[16:0]];
      if (o_mem_wr) begin
        if (o_mem_a[17:16] == IO_SEL) begin
          if (o_mem_a[15:0] == IO_OUT_ADDR[15:0]) begin
            check("i_io_buffer_full", 32'(i_io_buffer_full), 32'd0);
            out_q.push_back(o_mem_dout);
            n_out++;
          end
        end else begin
          mem[o_mem_a[16:0]] = o_mem_dout;
        end
      end
    end
  end

  // inputs change on the falling edge only
  always @(negedge clk_in) begin
    i_mem_din        = rd_q;
    i_rdy            = rdy_rand ? (($random(seed) & 3) != 0) : 1'b1;
    i_io_buffer_full = full_rand ? (($random(seed) & 1) != 0) : 1'b0;
  end

  // compare process
  always @(negedge clk_in) begin
    logic [7:0]  b;
    logic [7:0]  e;
    int          len;
    logic [31:0] x10;
    while (out_q.size() > 0) begin
      b = out_q.pop_front();
      e = expected_output(cur_prog, n_seen, len, x10);
      if (n_seen >= len)
        stop_run("core printed more chars than the program writes");
      check("o_mem_dout", 32'(b), 32'(e));
      n_seen++;
    end
  end

  always @(posedge clk_in) begin
    if (running) begin
      cycles++;
      if (cycles > LIMIT)
        stop_run("timeout, program did not halt in time");
    end
  end

  task automatic run_prog(input int p, input bit rdy_r, input bit full_r);
    int          len;
    int          out_at_halt;
    logic [31:0] x10;
    logic [7:0]  unused;
    rst_req = 1'b1;
    load_prog(p);
    cur_prog  = p;
    n_seen    = 0;
    n_out     = 0;
    out_q.delete();
    rdy_rand  = rdy_r;
    full_rand = full_r;
    repeat (5) @(negedge clk_in);
    rst_req = 1'b0;
    cycles  = 0;
    running = 1'b1;
    while (!o_halted) @(negedge clk_in);
    running     = 1'b0;
    out_at_halt = n_out;
    repeat (20) begin
      @(negedge clk_in);
      check("o_mem_wr", 32'(o_mem_wr), 32'd0);   // no bus writes after halt
      check("o_halted", 32'(o_halted), 32'd1);
    end
    unused = expected_output(p, 0, len, x10);
    check("n_out", 32'(n_out), 32'(out_at_halt));
    check("n_seen", 32'(n_seen), 32'(len));
    check("o_dbgreg_dout", o_dbgreg_dout, x10);
  endtask

  initial begin
    seed             = 32'h90a1330a;
    rst_req          = 1'b0;
    i_rdy            = 1'b1;
    i_io_buffer_full = 1'b0;
    i_mem_din        = 8'h00;
    rd_q             = 8'h00;
    rdy_rand         = 1'b0;
    full_rand        = 1'b0;
    running          = 1'b0;
    cur_prog         = 0;
    n_seen           = 0;
    n_out            = 0;
    cycles           = 0;
    run_prog(0, 1'b0, 1'b0);   // arithmetic
    run_prog(1, 1'b0, 1'b0);   // word and byte memory
    run_prog(2, 1'b0, 1'b0);   // loop
    run_prog(3, 1'b1, 1'b0);   // loop with pauses
    run_prog(4, 1'b0, 1'b1);   // loop with buffer stalls
    $display("TB PASSED");
    $finish;
  end

endmodule

/* build.f */
design/rv_pkg.sv
design/byte_counter.sv
design/decoder.sv
design/reg_file.sv
design/alu.sv
design/mem_port.sv
design/cpu_ctrl.sv
design/cpu.sv
verification/tb_clock.sv
verification/tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rv32i subset core testbench with Verilator and runs it
# the exit status is the simulator's, nonzero when the testbench fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_cpu \
  --Mdir obj_dir -o tb_cpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit $status
fi

./obj_dir/tb_cpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0
